// ==== sim/ex_stim.txt ====
# I lane npc ppc ir dest rega regb opa opb func cbr ubr rd wr exp_result exp_mispred exp_br
# M tag value (value is also the expected result); N is an idle cycle; all fields hex
I 1 1004 1004 00000000 01 5 7 0 0 00 0 0 0 0 c 0 0
I 2 1008 1008 00000000 02 10 3 0 0 01 0 0 0 0 d 0 0
I 1 100c 100c 00000000 03 ff00 0ff0 0 0 02 0 0 0 0 f00 0 0
I 2 1010 1010 00000000 04 f000 000f 0 0 04 0 0 0 0 f00f 0 0
I 1 1014 1014 00000000 05 ffff 00ff 0 0 06 0 0 0 0 ff00 0 0
I 2 1018 1018 00008000 06 3 0 0 1 09 0 0 0 0 30 0 0
I 1 101c 101c 00000000 07 100 44 0 0 08 0 0 0 0 10 0 0
I 2 1020 1020 00000000 08 8000000000000000 4 0 0 0a 0 0 0 0 f800000000000000 0 0
I 1 1024 1024 00000000 09 5 5 0 0 0c 0 0 0 0 1 0 0
I 2 1028 1028 00000000 0a ffffffffffffffff 1 0 0 0d 0 0 0 0 1 0 0
I 1 102c 102c 00000000 0b ffffffffffffffff 1 0 0 0f 0 0 0 0 0 0 0
I 2 1030 1030 0000fff0 0c 0 100 1 0 00 0 0 0 0 f0 0 0
N
I 1 2004 2010 00000003 0d 0 0 2 2 00 0 1 0 0 2010 0 3
I 2 3004 3004 04000004 0e 0 0 2 2 00 1 0 0 0 3014 1 3
I 1 4004 4004 14000008 0f 0 0 2 2 00 1 0 0 0 4004 0 2
I 2 5004 5004 081ffffe 10 ffffffffffffffff 0 2 2 00 1 0 0 0 4ffc 1 3
I 1 6004 7000 1c000001 11 0 0 2 2 00 1 0 0 0 6004 1 2
N
I 1 1040 1040 00000020 12 0 8000 1 0 00 0 0 1 0 8020 0 0
I 2 1044 1044 0000fff8 13 deadbeef 9000 1 0 00 0 0 0 1 8ff8 0 0
M 12 123456789abcdef0
N
I 2 1050 1050 00000000 14 ffffffffffffffff 5 0 0 0b 0 0 0 0 fffffffffffffffb 0 0
I 1 1054 1054 00000000 15 100000001 3 0 0 0b 0 0 0 0 300000003 0 0
I 1 1058 1058 00000000 16 123456789 10000 0 0 0b 0 0 0 0 1234567890000 0 0
N
M 18 0f0f0f0f0f0f0f0f
I 1 105c 105c 00000000 17 20 22 0 0 00 0 0 0 0 42 0 0
I 2 1060 1060 00000000 19 7 6 0 0 0b 0 0 0 0 2a 0 0
I 2 1064 1064 00000000 1a 1 2 0 0 00 0 0 0 0 3 0 0
N
N

// ==== sources.f ====
hdl/isa_pkg.sv
hdl/ex_pkg.sv
hdl/ex_result_if.sv
hdl/alu.sv
hdl/mult.sv
hdl/ex_lane.sv
hdl/result_arbiter.sv
hdl/ex_stage.sv
sim/ex_stage_tb.sv

// ==== Bender.yml ====
package:
  name: ex_stage

sources:
  - hdl/isa_pkg.sv
  - hdl/ex_pkg.sv
  - hdl/ex_result_if.sv
  - hdl/alu.sv
  - hdl/mult.sv
  - hdl/ex_lane.sv
  - hdl/result_arbiter.sv
  - hdl/ex_stage.sv
  - target: test
    files:
      - sim/ex_stage_tb.sv

// ==== sim/ex_stage_tb.sv ====
/*
 * Self-checking testbench for the dual-issue execute stage.
 * Records from the stimulus file drive the lanes and the memory return;
 * result beats are matched against expected entries by tag.
 */
`timescale 1ns/10ps

module ex_stage_tb;

  localparam int mult_stages = ex_pkg::mult_stages_default;
  localparam int hold_limit  = 20;  // Cycles a lane may stall
  localparam int drain_limit = 60;

  logic        clock;
  logic        rst_n;
  logic        valid_in_1, valid_in_2;
  logic [63:0] npc_1, npc_2, ppc_1, ppc_2, rega_1, rega_2, regb_1, regb_2;
  logic [7:0]  pht_idx_1, pht_idx_2;
  logic [31:0] ir_1, ir_2;
  logic [4:0]  dest_reg_1, dest_reg_2, alu_func_1, alu_func_2, mem_tag;
  logic [1:0]  opa_select_1, opa_select_2, opb_select_1, opb_select_2;
  logic        cond_branch_1, cond_branch_2, uncond_branch_1, uncond_branch_2;
  logic        rd_mem_1, rd_mem_2, wr_mem_1, wr_mem_2, mem_valid;
  logic [63:0] mem_value;
  logic        stall_bus_1, stall_bus_2, ex_valid_1, ex_valid_2;
  logic        ex_mispredict_1, ex_mispredict_2, lsq_valid_1, lsq_valid_2;
  logic [63:0] ex_npc_1, ex_npc_2, ex_result_1, ex_result_2;
  logic [4:0]  ex_dest_reg_1, ex_dest_reg_2, lsq_tag_1, lsq_tag_2;
  logic [1:0]  ex_branch_result_1, ex_branch_result_2;
  logic [7:0]  ex_pht_idx_1, ex_pht_idx_2;
  logic [63:0] lsq_address_1, lsq_address_2, lsq_value_1, lsq_value_2;

  // Expected entries by destination tag
  logic [63:0] exp_result [32];
  logic        exp_misp   [32];
  logic [1:0]  exp_br     [32];
  logic [63:0] exp_npc    [32];
  logic [7:0]  exp_pht    [32];
  logic        pending    [32];
  logic        exact      [32];
  int          exp_cyc    [32];
  int          pending_cnt;
  int          mismatches;
  int          failures;
  int          cyc;
  logic        aborted;

  // Fields of the current record
  logic [63:0] r_lane, r_npc, r_ppc, r_ir, r_dest, r_rega, r_regb, r_opa, r_opb;
  logic [63:0] r_func, r_cb, r_ub, r_rd, r_wr, r_res, r_misp, r_br;

  ex_stage u_dut (.*);

  initial
  begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  always @(posedge clock or negedge rst_n)
    if (!rst_n)
      cyc <= 0;
    else
      cyc <= cyc + 1;

  task automatic compare_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
      mismatches++;
      $display("MISMATCH at %0t: %s = %h, expected %h", $time, name, got, exp);
    end
  endtask

  task automatic clear_inputs();
    {valid_in_1, valid_in_2, mem_valid} = '0;
    {npc_1, npc_2, ppc_1, ppc_2, rega_1, rega_2, regb_1, regb_2} = '0;
    {pht_idx_1, pht_idx_2, ir_1, ir_2, dest_reg_1, dest_reg_2} = '0;
    {alu_func_1, alu_func_2, mem_tag, mem_value} = '0;
    {opa_select_1, opa_select_2, opb_select_1, opb_select_2} = '0;
    {cond_branch_1, cond_branch_2, uncond_branch_1, uncond_branch_2} = '0;
    {rd_mem_1, rd_mem_2, wr_mem_1, wr_mem_2} = '0;
  endtask

  task automatic add_expect(input int tag, input logic [63:0] res, input logic misp,
                            input logic [1:0] br, input logic [63:0] npc,
                            input logic [7:0] pht, input logic is_exact, input int when);
    if (pending[tag])
    begin
      failures++;
      $display("Tag %0d was issued again before its result came back", tag);
    end
    pending[tag]    = 1'b1;
    exp_result[tag] = res;
    exp_misp[tag]   = misp;
    exp_br[tag]     = br;
    exp_npc[tag]    = npc;
    exp_pht[tag]    = pht;
    exact[tag]      = is_exact;
    exp_cyc[tag]    = when;
    pending_cnt++;
  endtask

  task automatic take_beat(input int bus, input int tag, input logic [63:0] res,
                           input logic misp, input logic [1:0] br,
                           input logic [63:0] npc, input logic [7:0] pht);
    if (!pending[tag])
    begin
      failures++;
      $display("Unexpected result beat on bus %0d for tag %0d at %0t", bus, tag, $time);
    end
    else
    begin
      compare_value($sformatf("ex_result_%0d", bus), res, exp_result[tag]);
      compare_value($sformatf("ex_mispredict_%0d", bus), misp, exp_misp[tag]);
      compare_value($sformatf("ex_branch_result_%0d", bus), br, exp_br[tag]);
      compare_value($sformatf("ex_npc_%0d", bus), npc, exp_npc[tag]);
      compare_value($sformatf("ex_pht_idx_%0d", bus), pht, exp_pht[tag]);
      if (exact[tag])
        compare_value($sformatf("ex_valid_%0d cycle", bus), cyc, exp_cyc[tag]);
      else if (cyc < exp_cyc[tag])
      begin
        failures++;
        $display("Multiplier result for tag %0d arrived too early at %0t", tag, $time);
      end
      pending[tag] = 1'b0;
      pending_cnt--;
    end
  endtask

  always @(negedge clock)
  begin
    if (rst_n && ex_valid_1)
      take_beat(1, ex_dest_reg_1, ex_result_1, ex_mispredict_1, ex_branch_result_1,
                ex_npc_1, ex_pht_idx_1);
    if (rst_n && ex_valid_2)
      take_beat(2, ex_dest_reg_2, ex_result_2, ex_mispredict_2, ex_branch_result_2,
                ex_npc_2, ex_pht_idx_2);
  end

  task automatic drive_issue();
    if (r_lane == 1)
      {valid_in_1, npc_1, ppc_1, ir_1, dest_reg_1, pht_idx_1, rega_1, regb_1,
       opa_select_1, opb_select_1, alu_func_1, cond_branch_1, uncond_branch_1,
       rd_mem_1, wr_mem_1} = {1'b1, r_npc, r_ppc, r_ir[31:0], r_dest[4:0], r_dest[7:0],
                              r_rega, r_regb, r_opa[1:0], r_opb[1:0], r_func[4:0],
                              r_cb[0], r_ub[0], r_rd[0], r_wr[0]};
    else
      {valid_in_2, npc_2, ppc_2, ir_2, dest_reg_2, pht_idx_2, rega_2, regb_2,
       opa_select_2, opb_select_2, alu_func_2, cond_branch_2, uncond_branch_2,
       rd_mem_2, wr_mem_2} = {1'b1, r_npc, r_ppc, r_ir[31:0], r_dest[4:0], r_dest[7:0],
                              r_rega, r_regb, r_opa[1:0], r_opb[1:0], r_func[4:0],
                              r_cb[0], r_ub[0], r_rd[0], r_wr[0]};
  endtask

  // Holds the issue until the lane accepts it, then checks the LSQ request
  task automatic accept_issue();
    int waited;
    waited = 0;
    @(negedge clock);
    while ((r_lane == 1 ? stall_bus_1 : stall_bus_2) && !aborted)
    begin
      waited++;
      if (waited > hold_limit)
      begin
        failures++;
        aborted = 1'b1;
        $display("Timeout: lane %0d stayed stalled for %0d cycles", r_lane, hold_limit);
      end
      else
        @(negedge clock);
    end
    if (!aborted)
    begin
      compare_value("lsq_valid", r_lane == 1 ? lsq_valid_1 : lsq_valid_2, r_rd | r_wr);
      if (r_rd | r_wr)
      begin
        compare_value("lsq_address", r_lane == 1 ? lsq_address_1 : lsq_address_2, r_res);
        compare_value("lsq_value", r_lane == 1 ? lsq_value_1 : lsq_value_2, r_rega);
        compare_value("lsq_tag", r_lane == 1 ? lsq_tag_1 : lsq_tag_2, r_dest);
      end
      if (r_func == 64'h0b)  // Lane 1 multiplier is never frozen
        add_expect(r_dest, r_res, r_misp, r_br, r_npc, 8'h00, r_lane == 1,
                   cyc + 1 + mult_stages);
      else if (!r_rd)  // Loads write back through memory
        add_expect(r_dest, r_res, r_misp, r_br, r_npc, r_dest[7:0], 1'b1, cyc + 1);
    end
  endtask

  initial
  begin
    int                 fd;
    int                 n;
    int                 waited;
    logic [8*8-1:0]     kind;
    logic [8*200-1:0]   skip;
    for (int i = 0; i < 32; i++)
      pending[i] = 1'b0;
    {pending_cnt, mismatches, failures} = '0;
    aborted = 1'b0;
    clear_inputs();
    rst_n = 1'b0;
    repeat (5) @(posedge clock);
    #1 rst_n = 1'b1;

    ////////////////////
    // Idle after reset
    repeat (2)
    begin
      @(negedge clock);
      compare_value("ex_valid_1", ex_valid_1, 0);
      compare_value("ex_valid_2", ex_valid_2, 0);
      compare_value("lsq_valid_1", lsq_valid_1, 0);
      compare_value("lsq_valid_2", lsq_valid_2, 0);
      compare_value("stall_bus_1", stall_bus_1, 0);
      compare_value("stall_bus_2", stall_bus_2, 0);
    end

    fd = $fopen("sim/ex_stim.txt", "r");
    if (fd == 0)
    begin
      failures++;
      aborted = 1'b1;
      $display("Could not open the stimulus file sim/ex_stim.txt");
    end
    while (!aborted && $fscanf(fd, "%s", kind) == 1)
    begin
      if (kind == "#")
        n = $fgets(skip, fd);  // Comment line
      else
      begin
        @(posedge clock);
        #1;
        clear_inputs();
        if (kind == "I")
        begin
          n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", r_lane, r_npc, r_ppc, r_ir,
                      r_dest, r_rega, r_regb, r_opa, r_opb);
          n += $fscanf(fd, "%h %h %h %h %h %h %h %h", r_func, r_cb, r_ub, r_rd, r_wr,
                       r_res, r_misp, r_br);
          if (n != 17)
          begin
            failures++;
            aborted = 1'b1;
            $display("Malformed issue record in the stimulus file");
          end
          else
          begin
            drive_issue();
            accept_issue();
          end
        end
        else if (kind == "M")
        begin
          n = $fscanf(fd, "%h %h", r_dest, r_res);
          if (n != 2)
          begin
            failures++;
            aborted = 1'b1;
            $display("Malformed memory record in the stimulus file");
          end
          else
          begin
            mem_valid = 1'b1;
            mem_tag   = r_dest;
            mem_value = r_res;
            add_expect(r_dest, r_res, 1'b0, 2'b00, 64'h0, 8'h00, 1'b1, cyc + 1);
          end
        end
      end
    end
    @(posedge clock);
    #1 clear_inputs();

    // Drain the remaining results
    waited = 0;
    while (pending_cnt > 0 && !aborted)
    begin
      @(posedge clock);
      waited++;
      if (waited > drain_limit)
      begin
        failures++;
        aborted = 1'b1;
        $display("Timeout: %0d results never appeared on the buses", pending_cnt);
      end
    end

    $display("Errors: %0d value mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0)
      $display("Result: PASSED");
    else
      $display("Result: FAILED");
    $finish;
  end

endmodule

// ==== hdl/ex_stage.sv ====
/*
 * Dual-issue execute stage.
 * Two lanes feed the result arbiter. Memory returns enter on
 * bus 2; stall_bus_n holds issue on lane n.
 */
`timescale 1ns/10ps

module ex_stage #(
  parameter int HISTORY_BITS = ex_pkg::history_bits_default,
  parameter int MULT_STAGES  = ex_pkg::mult_stages_default
) (
  input  logic                              clock,
  input  logic                              rst_n,
  // Issue lanes
  input  logic                              valid_in_1, valid_in_2,
  input  logic [isa_pkg::xlen-1:0]          npc_1, npc_2,
  input  logic [isa_pkg::xlen-1:0]          ppc_1, ppc_2,
  input  logic [HISTORY_BITS-1:0]           pht_idx_1, pht_idx_2,
  input  logic [isa_pkg::inst_bits-1:0]     ir_1, ir_2,
  input  logic [ex_pkg::tag_bits-1:0]       dest_reg_1, dest_reg_2,
  input  logic [isa_pkg::xlen-1:0]          rega_1, rega_2,
  input  logic [isa_pkg::xlen-1:0]          regb_1, regb_2,
  input  logic [1:0]                        opa_select_1, opa_select_2,
  input  logic [1:0]                        opb_select_1, opb_select_2,
  input  logic [4:0]                        alu_func_1, alu_func_2,
  input  logic                              cond_branch_1, cond_branch_2,
  input  logic                              uncond_branch_1, uncond_branch_2,
  input  logic                              rd_mem_1, rd_mem_2,
  input  logic                              wr_mem_1, wr_mem_2,
  // Memory return
  input  logic [ex_pkg::tag_bits-1:0]       mem_tag,
  input  logic [isa_pkg::xlen-1:0]          mem_value,
  input  logic                              mem_valid,
  output logic                              stall_bus_1, stall_bus_2,
  // Result buses
  output logic [isa_pkg::xlen-1:0]          ex_npc_1, ex_npc_2,
  output logic [ex_pkg::tag_bits-1:0]       ex_dest_reg_1, ex_dest_reg_2,
  output logic [isa_pkg::xlen-1:0]          ex_result_1, ex_result_2,
  output logic                              ex_mispredict_1, ex_mispredict_2,
  output logic [ex_pkg::br_result_bits-1:0] ex_branch_result_1, ex_branch_result_2,
  output logic [HISTORY_BITS-1:0]           ex_pht_idx_1, ex_pht_idx_2,
  output logic                              ex_valid_1, ex_valid_2,
  // Load/store queue
  output logic [ex_pkg::tag_bits-1:0]       lsq_tag_1, lsq_tag_2,
  output logic [isa_pkg::xlen-1:0]          lsq_address_1, lsq_address_2,
  output logic [isa_pkg::xlen-1:0]          lsq_value_1, lsq_value_2,
  output logic                              lsq_valid_1, lsq_valid_2
);

  logic lane_stall_1;
  logic lane_stall_2;
  logic mult_freeze_2;

  ex_result_if #(.HISTORY_BITS(HISTORY_BITS)) alu_res_1 ();
  ex_result_if #(.HISTORY_BITS(HISTORY_BITS)) mul_res_1 ();
  ex_result_if #(.HISTORY_BITS(HISTORY_BITS)) alu_res_2 ();
  ex_result_if #(.HISTORY_BITS(HISTORY_BITS)) mul_res_2 ();

  ex_lane #(
    .HISTORY_BITS (HISTORY_BITS),
    .MULT_STAGES  (MULT_STAGES)
  ) u_lane_1 (
    .clock (clock), .rst_n (rst_n), .valid_in (valid_in_1),
    .npc (npc_1), .ppc (ppc_1), .pht_idx (pht_idx_1), .ir (ir_1),
    .dest_reg (dest_reg_1), .rega (rega_1), .regb (regb_1),
    .opa_select (isa_pkg::opa_sel_t'(opa_select_1)),
    .opb_select (isa_pkg::opb_sel_t'(opb_select_1)),
    .alu_func (isa_pkg::alu_func_t'(alu_func_1)),
    .cond_branch (cond_branch_1), .uncond_branch (uncond_branch_1),
    .rd_mem (rd_mem_1), .wr_mem (wr_mem_1),
    .lane_stall (lane_stall_1),
    .mult_freeze (1'b0),  // Bus 1 multiplier always wins
    .stall_out (stall_bus_1),
    .lsq_tag (lsq_tag_1), .lsq_address (lsq_address_1),
    .lsq_value (lsq_value_1), .lsq_valid (lsq_valid_1),
    .alu_res (alu_res_1), .mul_res (mul_res_1)
  );

  ex_lane #(
    .HISTORY_BITS (HISTORY_BITS),
    .MULT_STAGES  (MULT_STAGES)
  ) u_lane_2 (
    .clock (clock), .rst_n (rst_n), .valid_in (valid_in_2),
    .npc (npc_2), .ppc (ppc_2), .pht_idx (pht_idx_2), .ir (ir_2),
    .dest_reg (dest_reg_2), .rega (rega_2), .regb (regb_2),
    .opa_select (isa_pkg::opa_sel_t'(opa_select_2)),
    .opb_select (isa_pkg::opb_sel_t'(opb_select_2)),
    .alu_func (isa_pkg::alu_func_t'(alu_func_2)),
    .cond_branch (cond_branch_2), .uncond_branch (uncond_branch_2),
    .rd_mem (rd_mem_2), .wr_mem (wr_mem_2),
    .lane_stall (lane_stall_2),
    .mult_freeze (mult_freeze_2),
    .stall_out (stall_bus_2),
    .lsq_tag (lsq_tag_2), .lsq_address (lsq_address_2),
    .lsq_value (lsq_value_2), .lsq_valid (lsq_valid_2),
    .alu_res (alu_res_2), .mul_res (mul_res_2)
  );

  result_arbiter #(
    .HISTORY_BITS (HISTORY_BITS)
  ) u_arbiter (
    .clock (clock), .rst_n (rst_n),
    .mem_tag (mem_tag), .mem_value (mem_value), .mem_valid (mem_valid),
    .alu_1 (alu_res_1), .mul_1 (mul_res_1),
    .alu_2 (alu_res_2), .mul_2 (mul_res_2),
    .lane_stall_1 (lane_stall_1), .lane_stall_2 (lane_stall_2),
    .mult_freeze_2 (mult_freeze_2),
    .ex_npc_1 (ex_npc_1), .ex_dest_reg_1 (ex_dest_reg_1),
    .ex_result_1 (ex_result_1), .ex_mispredict_1 (ex_mispredict_1),
    .ex_branch_result_1 (ex_branch_result_1), .ex_pht_idx_1 (ex_pht_idx_1),
    .ex_valid_1 (ex_valid_1),
    .ex_npc_2 (ex_npc_2), .ex_dest_reg_2 (ex_dest_reg_2),
    .ex_result_2 (ex_result_2), .ex_mispredict_2 (ex_mispredict_2),
    .ex_branch_result_2 (ex_branch_result_2), .ex_pht_idx_2 (ex_pht_idx_2),
    .ex_valid_2 (ex_valid_2)
  );

endmodule

// ==== hdl/result_arbiter.sv ====
/*
 * Merges lane, multiplier and memory results onto two
 * registered result buses and stalls the sources that lose.
 */
`timescale 1ns/10ps

module result_arbiter #(
  parameter int HISTORY_BITS = ex_pkg::history_bits_default
) (
  input  logic                              clock,
  input  logic                              rst_n,
  input  logic [ex_pkg::tag_bits-1:0]       mem_tag,
  input  logic [isa_pkg::xlen-1:0]          mem_value,
  input  logic                              mem_valid,
  ex_result_if.sink                         alu_1,
  ex_result_if.sink                         mul_1,
  ex_result_if.sink                         alu_2,
  ex_result_if.sink                         mul_2,
  output logic                              lane_stall_1,
  output logic                              lane_stall_2,
  output logic                              mult_freeze_2,
  output logic [isa_pkg::xlen-1:0]          ex_npc_1,
  output logic [ex_pkg::tag_bits-1:0]       ex_dest_reg_1,
  output logic [isa_pkg::xlen-1:0]          ex_result_1,
  output logic                              ex_mispredict_1,
  output logic [ex_pkg::br_result_bits-1:0] ex_branch_result_1,
  output logic [HISTORY_BITS-1:0]           ex_pht_idx_1,
  output logic                              ex_valid_1,
  output logic [isa_pkg::xlen-1:0]          ex_npc_2,
  output logic [ex_pkg::tag_bits-1:0]       ex_dest_reg_2,
  output logic [isa_pkg::xlen-1:0]          ex_result_2,
  output logic                              ex_mispredict_2,
  output logic [ex_pkg::br_result_bits-1:0] ex_branch_result_2,
  output logic [HISTORY_BITS-1:0]           ex_pht_idx_2,
  output logic                              ex_valid_2
);

  // Bus 1: mult_1 > alu_1.  Bus 2: memory > mult_2 > alu_2
  assign lane_stall_1  = alu_1.valid & mul_1.valid;
  assign mult_freeze_2 = mem_valid & mul_2.valid;
  assign lane_stall_2  = alu_2.valid & (mem_valid | mul_2.valid);

  always_ff @(posedge clock or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ex_valid_1 <= 1'b0;
      ex_valid_2 <= 1'b0;
    end
    else
    begin
      ex_valid_1 <= mul_1.valid | alu_1.valid;
      ex_valid_2 <= mem_valid | mul_2.valid | alu_2.valid;
    end
  end

  ////////////////////
  // Bus payloads
  always_ff @(posedge clock)
  begin
    if (mul_1.valid)
    begin
      ex_npc_1           <= mul_1.npc;
      ex_dest_reg_1      <= mul_1.dest;
      ex_result_1        <= mul_1.result;
      ex_mispredict_1    <= 1'b0;
      ex_branch_result_1 <= '0;
      ex_pht_idx_1       <= mul_1.pht_idx;
    end
    else
    begin
      ex_npc_1           <= alu_1.npc;
      ex_dest_reg_1      <= alu_1.dest;
      ex_result_1        <= alu_1.result;
      ex_mispredict_1    <= alu_1.mispredict;
      ex_branch_result_1 <= {alu_1.is_branch, alu_1.taken};
      ex_pht_idx_1       <= alu_1.pht_idx;
    end

    if (mem_valid)  // Memory returns are never refused
    begin
      ex_npc_2           <= '0;
      ex_dest_reg_2      <= mem_tag;
      ex_result_2        <= mem_value;
      ex_mispredict_2    <= 1'b0;
      ex_branch_result_2 <= '0;
      ex_pht_idx_2       <= '0;
    end
    else if (mul_2.valid)
    begin
      ex_npc_2           <= mul_2.npc;
      ex_dest_reg_2      <= mul_2.dest;
      ex_result_2        <= mul_2.result;
      ex_mispredict_2    <= 1'b0;
      ex_branch_result_2 <= '0;
      ex_pht_idx_2       <= mul_2.pht_idx;
    end
    else
    begin
      ex_npc_2           <= alu_2.npc;
      ex_dest_reg_2      <= alu_2.dest;
      ex_result_2        <= alu_2.result;
      ex_mispredict_2    <= alu_2.mispredict;
      ex_branch_result_2 <= {alu_2.is_branch, alu_2.taken};
      ex_pht_idx_2       <= alu_2.pht_idx;
    end
  end

endmodule

// ==== hdl/ex_lane.sv ====
/*
 * One issue lane of the execute stage.
 * Immediates, operand muxes, ALU, multiplier, branch resolution
 * and the load/store queue request.
 */
`timescale 1ns/10ps

module ex_lane #(
  parameter int HISTORY_BITS = ex_pkg::history_bits_default,
  parameter int MULT_STAGES  = ex_pkg::mult_stages_default
) (
  input  logic                            clock,
  input  logic                            rst_n,
  input  logic                            valid_in,
  input  logic [isa_pkg::xlen-1:0]        npc,       // PC+4
  input  logic [isa_pkg::xlen-1:0]        ppc,       // Predicted PC
  input  logic [HISTORY_BITS-1:0]         pht_idx,
  input  logic [isa_pkg::inst_bits-1:0]   ir,
  input  logic [ex_pkg::tag_bits-1:0]     dest_reg,
  input  logic [isa_pkg::xlen-1:0]        rega,
  input  logic [isa_pkg::xlen-1:0]        regb,
  input  isa_pkg::opa_sel_t               opa_select,
  input  isa_pkg::opb_sel_t               opb_select,
  input  isa_pkg::alu_func_t              alu_func,
  input  logic                            cond_branch,
  input  logic                            uncond_branch,
  input  logic                            rd_mem,
  input  logic                            wr_mem,
  input  logic                            lane_stall,   // From arbiter
  input  logic                            mult_freeze,
  output logic                            stall_out,
  output logic [ex_pkg::tag_bits-1:0]     lsq_tag,
  output logic [isa_pkg::xlen-1:0]        lsq_address,
  output logic [isa_pkg::xlen-1:0]        lsq_value,
  output logic                            lsq_valid,
  ex_result_if.source                     alu_res,
  ex_result_if.source                     mul_res
);

  localparam int xlen = isa_pkg::xlen;

  logic [xlen-1:0] mem_disp;
  logic [xlen-1:0] br_disp;
  logic [xlen-1:0] alu_imm;
  logic [xlen-1:0] opa_mux;
  logic [xlen-1:0] opb_mux;
  logic [xlen-1:0] alu_result;
  logic            is_mulq;
  logic            is_branch;
  logic            cond_true;
  logic            taken;

  ////////////////////
  // Immediates
  assign mem_disp = {{(xlen - isa_pkg::mem_disp_bits){ir[isa_pkg::mem_disp_bits-1]}},
                     ir[isa_pkg::mem_disp_bits-1:0]};
  assign br_disp  = {{(xlen - isa_pkg::br_disp_bits - 2){ir[isa_pkg::br_disp_bits-1]}},
                     ir[isa_pkg::br_disp_bits-1:0], 2'b00};
  assign alu_imm  = {{(xlen - isa_pkg::alu_imm_bits){1'b0}},
                     ir[isa_pkg::alu_imm_lsb +: isa_pkg::alu_imm_bits]};

  always_comb
  begin
    case (opa_select)
      isa_pkg::opa_is_rega:     opa_mux = rega;
      isa_pkg::opa_is_mem_disp: opa_mux = mem_disp;
      isa_pkg::opa_is_npc:      opa_mux = npc;
      default:                  opa_mux = ~64'h3;  // Branch target alignment
    endcase
    case (opb_select)
      isa_pkg::opb_is_regb:    opb_mux = regb;
      isa_pkg::opb_is_alu_imm: opb_mux = alu_imm;
      isa_pkg::opb_is_br_disp: opb_mux = br_disp;
      default:                 opb_mux = '0;
    endcase
  end

  alu u_alu (
    .opa    (opa_mux),
    .opb    (opb_mux),
    .func   (alu_func),
    .result (alu_result)
  );

  ////////////////////
  // Branch resolution
  always_comb
  begin
    case (isa_pkg::br_cond_t'(ir[isa_pkg::br_cond_lsb +: 3]))
      isa_pkg::br_lbc: cond_true = ~rega[0];
      isa_pkg::br_eq:  cond_true = rega == '0;
      isa_pkg::br_lt:  cond_true = rega[xlen-1];
      isa_pkg::br_le:  cond_true = rega[xlen-1] | (rega == '0);
      isa_pkg::br_lbs: cond_true = rega[0];
      isa_pkg::br_ne:  cond_true = rega != '0;
      isa_pkg::br_ge:  cond_true = ~rega[xlen-1];
      default:         cond_true = ~rega[xlen-1] & (rega != '0);  // GT
    endcase
  end

  assign is_branch = cond_branch | uncond_branch;
  assign taken     = uncond_branch | (cond_branch & cond_true);
  assign is_mulq   = alu_func == isa_pkg::alu_mulq;

  // MULQ under freeze holds issue as well
  assign stall_out = lane_stall | (mult_freeze & valid_in & is_mulq);

  assign alu_res.valid      = valid_in & ~is_mulq & ~rd_mem;  // Loads write back later
  assign alu_res.npc        = npc;
  assign alu_res.dest       = dest_reg;
  assign alu_res.result     = (is_branch & ~taken) ? npc : alu_result;
  assign alu_res.is_branch  = is_branch;
  assign alu_res.taken      = taken;
  assign alu_res.mispredict = taken ? (alu_result != ppc) : (ppc != npc);
  assign alu_res.pht_idx    = pht_idx;

  mult #(
    .MULT_STAGES (MULT_STAGES)
  ) u_mult (
    .clock    (clock),
    .rst_n    (rst_n),
    .mplier   (opa_mux),
    .mcand    (opb_mux),
    .npc_in   (npc),
    .dest_in  (dest_reg),
    .valid_in (valid_in & is_mulq & ~stall_out),
    .freeze   (mult_freeze),
    .res      (mul_res)
  );

  // Load/store queue request, once per accepted issue
  assign lsq_tag     = dest_reg;
  assign lsq_address = alu_result;
  assign lsq_value   = rega;
  assign lsq_valid   = valid_in & (rd_mem | wr_mem) & ~stall_out;

endmodule

// ==== hdl/mult.sv ====
/*
 * Pipelined 64-bit multiplier, low half of the product.
 * Each stage adds one partial product of xlen/MULT_STAGES bits.
 * NPC and tag ride along; freeze holds every stage.
 */
`timescale 1ns/10ps

module mult #(
  parameter int MULT_STAGES = ex_pkg::mult_stages_default
) (
  input  logic                        clock,
  input  logic                        rst_n,
  input  logic [isa_pkg::xlen-1:0]    mplier,
  input  logic [isa_pkg::xlen-1:0]    mcand,
  input  logic [isa_pkg::xlen-1:0]    npc_in,
  input  logic [ex_pkg::tag_bits-1:0] dest_in,
  input  logic                        valid_in,
  input  logic                        freeze,
  ex_result_if.source                 res
);

  localparam int chunk = isa_pkg::xlen / MULT_STAGES;

  logic [isa_pkg::xlen-1:0]    prod_q   [MULT_STAGES];
  logic [isa_pkg::xlen-1:0]    mplier_q [MULT_STAGES];
  logic [isa_pkg::xlen-1:0]    mcand_q  [MULT_STAGES];
  logic [isa_pkg::xlen-1:0]    npc_q    [MULT_STAGES];
  logic [ex_pkg::tag_bits-1:0] dest_q   [MULT_STAGES];
  logic                        valid_q  [MULT_STAGES];

  for (genvar s = 0; s < MULT_STAGES; s++)
  begin : g_stage
    logic [isa_pkg::xlen-1:0]    st_prod;
    logic [isa_pkg::xlen-1:0]    st_mplier;
    logic [isa_pkg::xlen-1:0]    st_mcand;
    logic [isa_pkg::xlen-1:0]    st_npc;
    logic [ex_pkg::tag_bits-1:0] st_dest;
    logic                        st_valid;

    if (s == 0)
    begin : g_first
      assign st_prod   = '0;
      assign st_mplier = mplier;
      assign st_mcand  = mcand;
      assign st_npc    = npc_in;
      assign st_dest   = dest_in;
      assign st_valid  = valid_in;
    end
    else
    begin : g_next
      assign st_prod   = prod_q[s-1];
      assign st_mplier = mplier_q[s-1];
      assign st_mcand  = mcand_q[s-1];
      assign st_npc    = npc_q[s-1];
      assign st_dest   = dest_q[s-1];
      assign st_valid  = valid_q[s-1];
    end

    always_ff @(posedge clock or negedge rst_n)
    begin
      if (!rst_n)
        valid_q[s] <= 1'b0;
      else if (!freeze)
        valid_q[s] <= st_valid;
    end

    always_ff @(posedge clock)
    begin
      if (!freeze)
      begin
        prod_q[s]   <= st_prod + st_mplier[chunk-1:0] * st_mcand;
        mplier_q[s] <= st_mplier >> chunk;  // Next multiplier digit
        mcand_q[s]  <= st_mcand << chunk;   // Weight of that digit
        npc_q[s]    <= st_npc;
        dest_q[s]   <= st_dest;
      end
    end
  end

  assign res.valid      = valid_q[MULT_STAGES-1];
  assign res.npc        = npc_q[MULT_STAGES-1];
  assign res.dest       = dest_q[MULT_STAGES-1];
  assign res.result     = prod_q[MULT_STAGES-1];
  assign res.is_branch  = 1'b0;  // Never a branch
  assign res.taken      = 1'b0;
  assign res.mispredict = 1'b0;
  assign res.pht_idx    = '0;

endmodule

// ==== hdl/alu.sv ====
/*
 * Combinational 64-bit integer ALU.
 * MULQ is handled by the multiplier and gives zero here.
 */
`timescale 1ns/10ps

module alu (
  input  logic [isa_pkg::xlen-1:0] opa,
  input  logic [isa_pkg::xlen-1:0] opb,
  input  isa_pkg::alu_func_t       func,
  output logic [isa_pkg::xlen-1:0] result
);

  logic [5:0] shamt;  // Low 6 bits of B
  logic       signed_lt;

  assign shamt     = opb[5:0];
  assign signed_lt = $signed(opa) < $signed(opb);

  always_comb
  begin
    case (func)
      isa_pkg::alu_addq:   result = opa + opb;
      isa_pkg::alu_subq:   result = opa - opb;
      isa_pkg::alu_and:    result = opa & opb;
      isa_pkg::alu_bis:    result = opa | opb;
      isa_pkg::alu_xor:    result = opa ^ opb;
      isa_pkg::alu_sll:    result = opa << shamt;
      isa_pkg::alu_srl:    result = opa >> shamt;
      isa_pkg::alu_sra:    result = $signed(opa) >>> shamt;
      isa_pkg::alu_cmpeq:  result = {63'd0, opa == opb};
      isa_pkg::alu_cmplt:  result = {63'd0, signed_lt};
      isa_pkg::alu_cmpult: result = {63'd0, opa < opb};
      default:             result = '0;  // MULQ and unused codes
    endcase
  end

endmodule

// ==== hdl/ex_result_if.sv ====
/*
 * One result source toward the result arbiter.
 * Lanes and multipliers drive it, the arbiter samples it.
 */
`timescale 1ns/10ps

interface ex_result_if #(
  parameter int HISTORY_BITS = ex_pkg::history_bits_default
);
  logic                        valid;
  logic [isa_pkg::xlen-1:0]    npc;
  logic [ex_pkg::tag_bits-1:0] dest;
  logic [isa_pkg::xlen-1:0]    result;
  logic                        is_branch;
  logic                        taken;
  logic                        mispredict;
  logic [HISTORY_BITS-1:0]     pht_idx;

  modport source (
    output valid, npc, dest, result, is_branch, taken, mispredict, pht_idx
  );
  modport sink (
    input valid, npc, dest, result, is_branch, taken, mispredict, pht_idx
  );
endinterface

// ==== hdl/ex_pkg.sv ====
/*
 * Execute-stage defaults and constants shared by the issue lanes,
 * the multiplier and the result arbiter.
 */
package ex_pkg;

  localparam int history_bits_default = 8;  // Predictor table index
  localparam int mult_stages_default  = 4;  // Multiplier depth

  // Physical destination tag
  localparam int tag_bits = 5;

  // {is_branch, taken} on the result buses
  localparam int br_result_bits = 2;

endpackage

// ==== hdl/isa_pkg.sv ====
/*
 * Alpha-style ISA encodings used by the execute stage.
 * ALU function codes, operand selects, branch conditions and
 * the positions of the immediate fields in the instruction word.
 */
package isa_pkg;

  localparam int xlen      = 64;  // Fixed by the ISA
  localparam int inst_bits = 32;

  ////////////////////
  // ALU function codes
  typedef enum logic [4:0] {
    alu_addq   = 5'h00,
    alu_subq   = 5'h01,
    alu_and    = 5'h02,
    alu_bis    = 5'h04,
    alu_xor    = 5'h06,
    alu_srl    = 5'h08,
    alu_sll    = 5'h09,
    alu_sra    = 5'h0a,
    alu_mulq   = 5'h0b,  // Goes to the multiplier
    alu_cmpeq  = 5'h0c,
    alu_cmplt  = 5'h0d,
    alu_cmpult = 5'h0f
  } alu_func_t;

  typedef enum logic [1:0] {
    opa_is_rega     = 2'd0,
    opa_is_mem_disp = 2'd1,
    opa_is_npc      = 2'd2,
    opa_is_not3     = 2'd3
  } opa_sel_t;

  // Code 3 selects zero
  typedef enum logic [1:0] {
    opb_is_regb    = 2'd0,
    opb_is_alu_imm = 2'd1,
    opb_is_br_disp = 2'd2
  } opb_sel_t;

  // Tested against register A
  typedef enum logic [2:0] {
    br_lbc, br_eq, br_lt, br_le, br_lbs, br_ne, br_ge, br_gt
  } br_cond_t;

  ////////////////////
  // Instruction fields
  localparam int br_cond_lsb   = 26;  // ir[28:26]
  localparam int mem_disp_bits = 16;  // Sign extended
  localparam int br_disp_bits  = 21;  // Sign extended, word offset
  localparam int alu_imm_lsb   = 13;
  localparam int alu_imm_bits  = 8;   // Zero extended

endpackage
